//--- Makefile
# Verilator build and run for the PE row testbench.

VERILATOR  ?= verilator
TOP        ?= pe_row_tb
FLIST      ?= pe_row_top.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= TEST PASSED

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FLIST))

.PHONY: all run build lint clean

all: run

build: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run passes only when the pass line shows up in the simulator output.
run: build
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/pe_accum_stage.sv
`timescale 1ns/1ns
`default_nettype none

module pe_accum_stage (
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  wire               i_rdy,
    output logic              o_ack,
    input  pe_cfg_pkg::sum_t  i_sum  [pe_cfg_pkg::PEROW],
    input  pe_cfg_pkg::psum_t i_psum [pe_cfg_pkg::PEROW],
    input  wire               i_relu,
    output logic              o_rdy,
    input  wire               i_ack,
    output pe_cfg_pkg::psum_t o_psum [pe_cfg_pkg::PEROW]
);

    import pe_cfg_pkg::*;

    psum_t acc [PEROW];
    psum_t res [PEROW];
    logic  take;

    always_comb begin
        for (int i = 0; i < PEROW; i++) begin
            acc[i] = i_psum[i] + psum_t'(i_sum[i]);  // Wraps at PSUMDWD.
            if (i_relu && acc[i][PSUMDWD-1]) begin
                res[i] = '0;
            end else begin
                res[i] = acc[i];
            end
        end
    end

    assign o_ack = !o_rdy || i_ack;
    assign take  = i_rdy && o_ack;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdy <= 1'b0;
        end else if (take) begin
            o_rdy <= 1'b1;
        end else if (i_ack) begin
            o_rdy <= 1'b0;               // Sink took the result.
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < PEROW; i++) begin
                o_psum[i] <= '0;
            end
        end else if (take) begin
            for (int i = 0; i < PEROW; i++) begin
                o_psum[i] <= res[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/pe_cfg_pkg.sv
`default_nettype none

package pe_cfg_pkg;

    localparam int DWD     = 8;          // Pixel and weight width.
    localparam int ASUMDWD = 2 * DWD;    // Full product width.
    localparam int PSUMDWD = 20;         // Partial sums wrap at this width.
    localparam int PEROW   = 4;          // Lanes in one row.

    typedef logic signed [DWD-1:0]     pix_t;
    typedef logic signed [ASUMDWD-1:0] sum_t;
    typedef logic signed [PSUMDWD-1:0] psum_t;

    // One beat as held by the fetch register.
    typedef struct packed {
        pix_t  [PEROW-1:0] ipix;
        pix_t  [PEROW-1:0] wpix;
        psum_t [PEROW-1:0] psum;
        logic              skip;         // Zero-padding beat, product forced to zero.
        logic              relu;         // Clamp negative results of this beat.
    } fs_payload_t;

endpackage

`default_nettype wire

//--- hdl/pe_mult_stage.sv
`timescale 1ns/1ns
`default_nettype none

module pe_mult_stage (
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  wire               i_rdy,
    output logic              o_ack,
    input  pe_cfg_pkg::pix_t  i_ipix [pe_cfg_pkg::PEROW],
    input  pe_cfg_pkg::pix_t  i_wpix [pe_cfg_pkg::PEROW],
    input  pe_cfg_pkg::psum_t i_psum [pe_cfg_pkg::PEROW],
    input  wire               i_skip,
    input  wire               i_relu,
    output logic              o_rdy,
    input  wire               i_ack,
    output pe_cfg_pkg::sum_t  o_sum  [pe_cfg_pkg::PEROW],
    output pe_cfg_pkg::psum_t o_psum [pe_cfg_pkg::PEROW],
    output logic              o_relu
);

    import pe_cfg_pkg::*;

    sum_t prod [PEROW];
    logic take;

    genvar lane;
    generate
        for (lane = 0; lane < PEROW; lane++) begin : g_lane
            pe_mux_mult mult_i (
                .i_ipix (i_ipix[lane]),
                .i_wpix (i_wpix[lane]),
                .o_sum  (prod[lane])
            );
        end
    endgenerate

    assign o_ack = !o_rdy || i_ack;
    assign take  = i_rdy && o_ack;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdy <= 1'b0;
        end else if (take) begin
            o_rdy <= 1'b1;
        end else if (i_ack) begin
            o_rdy <= 1'b0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_relu <= 1'b0;
            for (int i = 0; i < PEROW; i++) begin
                o_sum[i]  <= '0;
                o_psum[i] <= '0;
            end
        end else if (take) begin
            o_relu <= i_relu;
            for (int i = 0; i < PEROW; i++) begin
                o_sum[i]  <= i_skip ? '0 : prod[i];  // Padding beats add nothing.
                o_psum[i] <= i_psum[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/pe_mux_mult.sv
`timescale 1ns/1ns
`default_nettype none

module pe_mux_mult (
    input  pe_cfg_pkg::pix_t i_ipix,
    input  pe_cfg_pkg::pix_t i_wpix,
    output pe_cfg_pkg::sum_t o_sum
);

    import pe_cfg_pkg::*;

    // Heap-ordered adder tree: nodes 0..DWD-2 add, nodes DWD-1..2*DWD-2 are leaves.
    sum_t node [2*DWD-1];
    sum_t ipix_ext;

    assign ipix_ext = sum_t'(i_ipix);    // Sign-extend once for all rows.

    genvar b;
    genvar k;
    generate
        for (b = 0; b < DWD; b++) begin : g_pp
            sum_t pp;
            assign pp = i_wpix[b] ? (ipix_ext <<< b) : '0;
            if (b == DWD - 1) begin : g_sign
                assign node[DWD-1+b] = -pp;  // Weight MSB carries negative weight.
            end else begin : g_mag
                assign node[DWD-1+b] = pp;
            end
        end

        for (k = 0; k < DWD - 1; k++) begin : g_tree
            assign node[k] = node[2*k+1] + node[2*k+2];
        end
    endgenerate

    assign o_sum = node[0];

endmodule

`default_nettype wire

//--- hdl/pe_pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pe_pipe_reg #(
    parameter type T = logic
) (
    input  wire  i_clk,
    input  wire  i_rst_n,
    input  wire  i_rdy,
    output logic o_ack,
    input  T     i_data,
    output logic o_rdy,
    input  wire  i_ack,
    output T     o_data
);

    logic take;

    assign o_ack = !o_rdy || i_ack;      // Free slot, or the slot drains this cycle.
    assign take  = i_rdy && o_ack;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdy <= 1'b0;
        end else if (take) begin
            o_rdy <= 1'b1;
        end else if (i_ack) begin
            o_rdy <= 1'b0;               // Taken with nothing behind it.
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data <= '0;
        end else if (take) begin
            o_data <= i_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pe_row_top.sv
`timescale 1ns/1ns
`default_nettype none

module pe_row_top (
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  wire               i_rdy,
    output logic              o_ack,
    input  pe_cfg_pkg::pix_t  i_ipix [pe_cfg_pkg::PEROW],
    input  pe_cfg_pkg::pix_t  i_wpix [pe_cfg_pkg::PEROW],
    input  pe_cfg_pkg::psum_t i_psum [pe_cfg_pkg::PEROW],
    input  wire               i_skip,
    input  wire               i_relu,
    output logic              o_rdy,
    input  wire               i_ack,
    output pe_cfg_pkg::psum_t o_psum [pe_cfg_pkg::PEROW]
);

    import pe_cfg_pkg::*;

    fs_payload_t fs_in;
    fs_payload_t fs_out;
    logic        fs_rdy;
    logic        fs_ack;
    pix_t        fs_ipix [PEROW];
    pix_t        fs_wpix [PEROW];
    psum_t       fs_psum [PEROW];

    logic        ms_rdy;
    logic        ms_ack;
    sum_t        ms_sum  [PEROW];
    psum_t       ms_psum [PEROW];
    logic        ms_relu;

    genvar lane;
    generate
        for (lane = 0; lane < PEROW; lane++) begin : g_lane
            assign fs_in.ipix[lane] = i_ipix[lane];  // Pack the beat for the fetch register.
            assign fs_in.wpix[lane] = i_wpix[lane];
            assign fs_in.psum[lane] = i_psum[lane];
            assign fs_ipix[lane]    = fs_out.ipix[lane];
            assign fs_wpix[lane]    = fs_out.wpix[lane];
            assign fs_psum[lane]    = fs_out.psum[lane];
        end
    endgenerate

    assign fs_in.skip = i_skip;
    assign fs_in.relu = i_relu;

    pe_pipe_reg #(
        .T (fs_payload_t)
    ) fs_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_rdy   (i_rdy),
        .o_ack   (o_ack),
        .i_data  (fs_in),
        .o_rdy   (fs_rdy),
        .i_ack   (fs_ack),
        .o_data  (fs_out)
    );

    pe_mult_stage ms_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_rdy   (fs_rdy),
        .o_ack   (fs_ack),
        .i_ipix  (fs_ipix),
        .i_wpix  (fs_wpix),
        .i_psum  (fs_psum),
        .i_skip  (fs_out.skip),
        .i_relu  (fs_out.relu),
        .o_rdy   (ms_rdy),
        .i_ack   (ms_ack),
        .o_sum   (ms_sum),
        .o_psum  (ms_psum),
        .o_relu  (ms_relu)
    );

    pe_accum_stage as_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_rdy   (ms_rdy),
        .o_ack   (ms_ack),
        .i_sum   (ms_sum),
        .i_psum  (ms_psum),
        .i_relu  (ms_relu),
        .o_rdy   (o_rdy),
        .i_ack   (i_ack),
        .o_psum  (o_psum)
    );

endmodule

`default_nettype wire

//--- pe_row_top.f
hdl/pe_cfg_pkg.sv
hdl/pe_pipe_reg.sv
hdl/pe_mux_mult.sv
hdl/pe_mult_stage.sv
hdl/pe_accum_stage.sv
hdl/pe_row_top.sv
tests/pe_row_checker.sv
tests/pe_row_tb.sv

//--- tests/pe_row_checker.sv
`timescale 1ns/1ns
`default_nettype none

module pe_row_checker (
    input wire               i_clk,
    input wire               i_rst_n,
    input wire               i_ack,
    input wire               o_rdy,
    input wire               o_ack,
    input pe_cfg_pkg::psum_t o_psum [pe_cfg_pkg::PEROW]
);

    import pe_cfg_pkg::*;

    logic [PEROW*PSUMDWD-1:0] psum_flat;

    always_comb begin
        for (int i = 0; i < PEROW; i++) begin
            psum_flat[i*PSUMDWD +: PSUMDWD] = o_psum[i];
        end
    end

    a_rdy_low_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !o_rdy)
        else $error("o_rdy is high while reset is asserted");

    // A stalled result must stay put until the sink takes it.
    a_hold_on_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_rdy && !i_ack) |=> (o_rdy && $stable(psum_flat)))
        else $error("output beat changed or vanished while stalled");

    a_ack_when_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_rdy |-> o_ack)
        else $error("o_ack is low although the output stage is empty");

endmodule

`default_nettype wire

//--- tests/pe_row_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pe_row_tb;

    import pe_cfg_pkg::*;

    localparam int          CLK_PERIOD = 100;
    localparam int          RST_CYCLES = 5;
    localparam int          NUM_BEATS  = 2000;
    localparam int          BURST      = 16;         // Opening beats with no stalls at all.
    localparam int          LATENCY    = 3;
    localparam int unsigned SEED       = 32'h897a_377a;
    localparam longint      TIMEOUT_NS = longint'(NUM_BEATS) * 8 * CLK_PERIOD;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_rdy;
    logic        o_ack;
    pix_t        i_ipix [PEROW];
    pix_t        i_wpix [PEROW];
    psum_t       i_psum [PEROW];
    logic        i_skip;
    logic        i_relu;
    logic        o_rdy;
    logic        i_ack;
    psum_t       o_psum [PEROW];

    psum_t       exp_q [$];                          // Expected lane results in arrival order.
    string       kind_q [$];
    int          n_in           = 0;
    int          n_out          = 0;
    int          cycle          = 0;
    int          first_in_cycle = 0;
    int          last_out_cycle = 0;
    logic        in_xfer        = 1'b0;

    pe_row_top dut_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_rdy   (i_rdy),
        .o_ack   (o_ack),
        .i_ipix  (i_ipix),
        .i_wpix  (i_wpix),
        .i_psum  (i_psum),
        .i_skip  (i_skip),
        .i_relu  (i_relu),
        .o_rdy   (o_rdy),
        .i_ack   (i_ack),
        .o_psum  (o_psum)
    );

    bind pe_row_top pe_row_checker checker_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ack   (i_ack),
        .o_rdy   (o_rdy),
        .o_ack   (o_ack),
        .o_psum  (o_psum)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end
    end

    task automatic compare(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Reference lane result is psum plus product wrapped to PSUMDWD and then the optional ReLU.
    function automatic psum_t model_lane(input pix_t ipix, input pix_t wpix, input psum_t psum,
                                         input logic skip, input logic relu);
        int    prod;
        int    full;
        psum_t res;
        prod = skip ? 0 : int'(ipix) * int'(wpix);
        full = int'(psum) + prod;
        res  = psum_t'(full);
        if (relu && res < 0) begin
            res = '0;
        end
        return res;
    endfunction

    function automatic pix_t rand_pix();
        case ($urandom_range(0, 7))
            0:       return 8'sh80;                   // Extremes show up often.
            1:       return 8'sh7f;
            default: return pix_t'($urandom);
        endcase
    endfunction

    function automatic psum_t rand_psum();
        case ($urandom_range(0, 3))
            0:       return psum_t'(32'h0007_ff00 + $urandom_range(0, 255));  // Near the top.
            1:       return psum_t'(32'h0008_0000 + $urandom_range(0, 255));  // Near the bottom.
            default: return psum_t'($urandom);
        endcase
    endfunction

    task automatic drive_inputs();
        logic rdy;
        if (!(i_rdy && !in_xfer)) begin               // No beat waiting, so a new one may start.
            if (n_in < BURST) begin
                rdy = 1'b1;
            end else begin
                rdy = ($urandom_range(0, 4) != 0);
            end
            i_rdy <= rdy;
            for (int lane = 0; lane < PEROW; lane++) begin
                i_ipix[lane] <= rand_pix();
                i_wpix[lane] <= rand_pix();
                i_psum[lane] <= rand_psum();
            end
            i_skip <= ($urandom_range(0, 7) == 0);
            i_relu <= ($urandom_range(0, 3) == 0);
        end
        if (n_out < BURST) begin
            i_ack <= 1'b1;
        end else begin
            i_ack <= ($urandom_range(0, 3) != 0);
        end
    endtask

    task automatic check_output();
        string kind;
        if (exp_q.size() < PEROW) begin
            $display("An output beat arrived with no input beat left to match it.");
            $display("TEST FAILED");
            $fatal(1, "unexpected output beat");
        end
        if (n_out == 0) begin
            compare("latency", LATENCY, cycle - first_in_cycle);
        end else if (n_out < BURST) begin
            compare("burst throughput", last_out_cycle + 1, cycle);
        end
        kind = kind_q.pop_front();
        for (int lane = 0; lane < PEROW; lane++) begin
            compare($sformatf("%s beat %0d lane %0d", kind, n_out, lane),
                    int'(exp_q.pop_front()), int'(o_psum[lane]));
        end
        last_out_cycle = cycle;
        n_out++;
    endtask

    // Sample mid-cycle where handshakes and data are settled for the coming edge.
    always @(negedge i_clk) begin
        cycle++;
        in_xfer = i_rst_n && i_rdy && o_ack;
        if (in_xfer) begin
            if (n_in == 0) begin
                first_in_cycle = cycle;
            end
            for (int lane = 0; lane < PEROW; lane++) begin
                exp_q.push_back(model_lane(i_ipix[lane], i_wpix[lane], i_psum[lane],
                                           i_skip, i_relu));
            end
            if (i_skip) begin
                kind_q.push_back("skip");
            end else if (i_relu) begin
                kind_q.push_back("relu");
            end else begin
                kind_q.push_back("mac");
            end
            n_in++;
        end
        if (i_rst_n && o_rdy && i_ack) begin
            check_output();
        end
    end

    initial begin
        void'($urandom(SEED));
        i_rst_n  = 1'b0;
        i_rdy    = 1'b0;
        i_ack    = 1'b0;
        i_skip   = 1'b0;
        i_relu   = 1'b0;
        for (int lane = 0; lane < PEROW; lane++) begin
            i_ipix[lane] = '0;
            i_wpix[lane] = '0;
            i_psum[lane] = '0;
        end
        repeat (RST_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;
        while (n_in < NUM_BEATS) begin
            drive_inputs();
            @(posedge i_clk);
        end
        i_rdy <= 1'b0;
        i_ack <= 1'b1;                                // Drain what is still in flight.
        repeat (LATENCY + 1) @(posedge i_clk);        // Every beat in flight is out by now.
        compare("leftover beats", 0, exp_q.size());
        $display("TEST PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns: the pipeline hung before all beats came out.",
                 TIMEOUT_NS);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
